/* project.f */
+incdir+include
hw/wb_pkg.sv
hw/lsu_fsm.sv
hw/bus_timeout.sv
hw/lsu_align.sv
hw/wb_stage.sv
hw/data_ram.sv
hw/mem_wb_top.sv
test/tb_clkgen.sv
test/tb_mem_wb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_mem_wb
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard include/*.svh hw/*.sv test/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass message shows up in the output
run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_mem_wb.sv */
// Directed testbench for the memory and writeback stage with its data RAM
// Each test task issues operations through valid/ready, waits for the
// writeback pulse and checks it against a byte-wide shadow of the RAM

`timescale 1ns/1ns

`include "wb_consts.svh"

module tb_mem_wb import wb_pkg::*; ();

	localparam int RAM_BYTES = `WB_RAM_BYTES;
	localparam int TIMEOUT = `WB_BUS_TIMEOUT;
	// Any single wait gives up well after the bus timeout
	localparam int WAIT_LIMIT = 8 * `WB_BUS_TIMEOUT + 16;

	logic       clk;
	logic       rst_n;
	logic       op_valid;
	logic       op_ready;
	wb_op_t     op;
	logic       wb_valid;
	wb_result_t wb_res;

	// Expected RAM contents with one entry per byte
	logic [7:0] shadow [RAM_BYTES];

	tb_clkgen u_clkgen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	mem_wb_top u_dut (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.op_valid_i (op_valid),
		.op_ready_o (op_ready),
		.op_i       (op),
		.wb_valid_o (wb_valid),
		.wb_res_o   (wb_res)
	);

	////////////////////////////////////////////////////////////
	// Checks and reference model
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] time %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("Error at time %0t: %s", $time, what);
			$display("Test FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	function automatic wb_op_t make_op(input logic [31:0] addr, input logic [31:0] wb_data,
			input logic [31:0] store_data, input load_type_e lt, input store_type_e st);
		wb_op_t o;
		o.addr       = addr;
		o.wb_data    = wb_data;
		o.store_data = store_data;
		o.load_type  = lt;
		o.store_type = st;
		return o;
	endfunction

	// Random word address inside the RAM
	function automatic logic [31:0] rand_word_addr();
		return ($urandom() % (RAM_BYTES / 4)) * 4;
	endfunction

	function automatic logic [31:0] shadow_word(input int unsigned a);
		return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
	endfunction

	// Little endian update of only the bytes covered by the access
	function automatic void shadow_store(input store_type_e st, input int unsigned a,
			input logic [31:0] d);
		shadow[a] = d[7:0];
		if (st == ST_H || st == ST_W) begin
			shadow[a+1] = d[15:8];
		end
		if (st == ST_W) begin
			shadow[a+2] = d[23:16];
			shadow[a+3] = d[31:24];
		end
	endfunction

	// Signed variants copy the top bit of the loaded byte or halfword upward
	function automatic logic [31:0] expected_load(input load_type_e lt, input int unsigned a);
		logic [7:0]  b;
		logic [15:0] h;
		b = shadow[a];
		case (lt)
			LD_B:  return {{24{b[7]}}, b};
			LD_BU: return {24'h0, b};
			LD_H: begin
				h = {shadow[a+1], b};
				return {{16{h[15]}}, h};
			end
			LD_HU: begin
				h = {shadow[a+1], b};
				return {16'h0, h};
			end
			default: return shadow_word(a);
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Operation driver
	////////////////////////////////////////////////////////////

	// Cycles are counted from the acceptance edge and sampled on falling edges
	task automatic issue_op(input wb_op_t o, output wb_result_t res, output int cycles);
		int waited;
		waited = 0;
		while (op_ready !== 1'b1) begin
			check_true(waited < WAIT_LIMIT, "timeout waiting for op_ready_o");
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		op_valid <= 1'b1;
		op       <= o;
		// Ready is still high on the acceptance edge
		@(posedge clk);
		op_valid <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			check_true(cycles <= WAIT_LIMIT, "timeout waiting for wb_valid_o");
			// Only one operation in flight
			check_value("op_ready_o", op_ready, 0);
		end while (wb_valid !== 1'b1);
		res = wb_res;
	endtask

	task automatic store_op(input store_type_e st, input logic [31:0] a, input logic [31:0] d);
		wb_result_t res;
		int         cycles;
		issue_op(make_op(a, 32'h0, d, LD_NONE, st), res, cycles);
		check_value("wb_res_o.err", res.err, 0);
		check_value("store latency", cycles, 3);
		shadow_store(st, a, d);
	endtask

	task automatic load_check(input load_type_e lt, input logic [31:0] a);
		wb_result_t res;
		int         cycles;
		issue_op(make_op(a, 32'h0, 32'h0, lt, ST_NONE), res, cycles);
		check_value("wb_res_o.err", res.err, 0);
		check_value("load latency", cycles, 3);
		check_value("wb_res_o.wdata", res.wdata, expected_load(lt, a));
	endtask

	// Faulting access that hands its latency back to the caller
	task automatic expect_error(input load_type_e lt, input store_type_e st,
			input logic [31:0] a, output int cycles);
		wb_result_t res;
		issue_op(make_op(a, $urandom(), $urandom(), lt, st), res, cycles);
		check_value("wb_res_o.err", res.err, 1);
		check_value("wb_res_o.wdata", res.wdata, 0);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic wait_reset();
		int waited;
		waited = 0;
		while (rst_n !== 1'b1) begin
			check_true(waited < WAIT_LIMIT, "reset was never released");
			@(negedge clk);
			waited++;
		end
		@(negedge clk);
		check_value("op_ready_o", op_ready, 1);
		check_value("wb_valid_o", wb_valid, 0);
		check_value("dbus req", u_dut.u_wb_stage.dbus_req_o.req, 0);
	endtask

	task automatic test_plain();
		wb_op_t     o;
		wb_result_t res;
		int         cycles;
		for (int i = 0; i < 8; i++) begin
			o = make_op($urandom(), $urandom(), $urandom(), LD_NONE, ST_NONE);
			issue_op(o, res, cycles);
			check_value("wb_res_o.wdata", res.wdata, o.wb_data);
			check_value("wb_res_o.err", res.err, 0);
			check_value("writeback latency", cycles, 1);
		end
	endtask

	// Every word gets a defined random value before any load
	task automatic fill_memory();
		for (int a = 0; a < RAM_BYTES; a += 4) begin
			store_op(ST_W, a, $urandom());
		end
	endtask

	task automatic test_word_rw();
		logic [31:0] a;
		for (int i = 0; i < 16; i++) begin
			a = rand_word_addr();
			store_op(ST_W, a, $urandom());
			load_check(LD_W, a);
			load_check(LD_W, rand_word_addr());
		end
	endtask

	// Word read back after each partial store shows which lanes moved
	task automatic test_subword_stores();
		logic [31:0] a;
		a = rand_word_addr();
		for (int off = 0; off < 4; off++) begin
			store_op(ST_B, a + off, $urandom());
			load_check(LD_W, a);
		end
		for (int off = 0; off < 4; off += 2) begin
			store_op(ST_H, a + off, $urandom());
			load_check(LD_W, a);
		end
	endtask

	task automatic test_subword_loads();
		logic [31:0] a;
		logic [31:0] d;
		for (int pass = 0; pass < 2; pass++) begin
			a = rand_word_addr();
			d = $urandom();
			// Top bit of every byte set on the first pass and clear on the second
			d = (pass == 0) ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);
			store_op(ST_W, a, d);
			for (int off = 0; off < 4; off++) begin
				load_check(LD_B, a + off);
				load_check(LD_BU, a + off);
			end
			for (int off = 0; off < 4; off += 2) begin
				load_check(LD_H, a + off);
				load_check(LD_HU, a + off);
			end
		end
	endtask

	task automatic test_misaligned();
		logic [31:0] a;
		int          cycles;
		a = rand_word_addr();
		for (int off = 1; off < 4; off++) begin
			expect_error(LD_W, ST_NONE, a + off, cycles);
			check_value("misaligned latency", cycles, 1);
			expect_error(LD_NONE, ST_W, a + off, cycles);
			check_value("misaligned latency", cycles, 1);
		end
		for (int off = 1; off < 4; off += 2) begin
			expect_error(LD_H, ST_NONE, a + off, cycles);
			check_value("misaligned latency", cycles, 1);
			expect_error(LD_NONE, ST_H, a + off, cycles);
			check_value("misaligned latency", cycles, 1);
		end
		// Shadow was left alone, so the RAM word must still match it
		load_check(LD_W, a);
	endtask

	task automatic test_out_of_range();
		logic [31:0] a;
		int          cycles;
		a = rand_word_addr();
		expect_error(LD_W, ST_NONE, a + RAM_BYTES, cycles);
		check_true(cycles >= TIMEOUT, "out-of-range load finished before the bus timeout");
		expect_error(LD_NONE, ST_W, a + RAM_BYTES, cycles);
		check_true(cycles >= TIMEOUT, "out-of-range store finished before the bus timeout");
		// The word with the same low address bits inside the RAM was not written
		load_check(LD_W, a);
		store_op(ST_W, a, $urandom());
		load_check(LD_W, a);
	endtask

	initial begin
		op_valid = 1'b0;
		op       = '0;
		void'($urandom(56024));
		wait_reset();
		test_plain();
		fill_memory();
		test_word_rw();
		test_subword_stores();
		test_subword_loads();
		test_misaligned();
		test_out_of_range();
		$display("Test OK");
		$finish;
	end

endmodule

/* test/tb_clkgen.sv */
// Clock and reset source for the writeback stage testbench
// Free running clock with a 4 ns period, reset held low for 8 cycles

`timescale 1ns/1ns

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	// Half period of 2 ns
	initial begin
		clk_o = 1'b0;
		forever begin
			#2 clk_o = ~clk_o;
		end
	end

	// Synchronous release on a rising edge
	initial begin
		rst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

/* hw/mem_wb_top.sv */
// Top level for simulation of the memory and writeback stage
// Connects the stage to its data RAM over the internal data bus

`timescale 1ns/1ns

module mem_wb_top import wb_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       op_valid_i,
	output logic       op_ready_o,
	input  wb_op_t     op_i,
	output logic       wb_valid_o,
	output wb_result_t wb_res_o
);

	dbus_req_t dbus_req;
	dbus_rsp_t dbus_rsp;

	wb_stage u_wb_stage (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.op_valid_i (op_valid_i),
		.op_ready_o (op_ready_o),
		.op_i       (op_i),
		.dbus_req_o (dbus_req),
		.dbus_rsp_i (dbus_rsp),
		.wb_valid_o (wb_valid_o),
		.wb_res_o   (wb_res_o)
	);

	data_ram u_data_ram (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (dbus_req),
		.rsp_o   (dbus_rsp)
	);

endmodule

/* hw/data_ram.sv */
// Single-port data RAM on the core data bus
// Grants in-range requests in the same cycle, writes enabled bytes on
// the grant and answers with rvalid one cycle later

`timescale 1ns/1ns

`include "wb_consts.svh"

module data_ram import wb_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  dbus_req_t req_i,
	output dbus_rsp_t rsp_o
);

	localparam int DEPTH = `WB_RAM_BYTES / 4;
	localparam int IDX_W = $clog2(DEPTH);

	logic [`WB_WORD_WIDTH-1:0] mem [DEPTH];
	logic [IDX_W-1:0]          idx;
	logic                      in_range;
	logic                      gnt;
	logic                      rvalid_q;
	logic [`WB_WORD_WIDTH-1:0] rdata_q;

	////////////////////////////////////////////////////////////
	// Grant
	////////////////////////////////////////////////////////////

	// Out-of-range requests are left hanging
	assign in_range = (req_i.addr < `WB_RAM_BYTES);
	assign gnt      = req_i.req & in_range;

	// Word index, byte offset dropped
	assign idx = req_i.addr[IDX_W+1:2];

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (gnt && req_i.we) begin
			for (int i = 0; i < 4; i++) begin
				if (req_i.be[i]) begin
					mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
				end
			end
		end
	end

	// Read word for the response cycle
	always_ff @(posedge clk) begin
		if (gnt && !req_i.we) begin
			rdata_q <= mem[idx];
		end
	end

	// Writes are acknowledged the same way as reads
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= gnt;
		end
	end

	always_comb begin
		rsp_o.gnt    = gnt;
		rsp_o.rvalid = rvalid_q;
		rsp_o.rdata  = rdata_q;
	end

endmodule

/* hw/wb_stage.sv */
// Memory and writeback stage of the core
// Accepts one operation through valid/ready, runs its data bus access
// if any, and pulses wb_valid_o once with the writeback value

`timescale 1ns/1ns

`include "wb_consts.svh"

module wb_stage import wb_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       op_valid_i,
	output logic       op_ready_o,
	input  wb_op_t     op_i,
	output dbus_req_t  dbus_req_o,
	input  dbus_rsp_t  dbus_rsp_i,
	output logic       wb_valid_o,
	output wb_result_t wb_res_o
);

	wb_op_t                    op_q;
	wb_op_t                    op_cur;
	logic [`WB_WORD_WIDTH-1:0] load_q;
	logic                      busy;
	logic                      start;
	logic                      is_load;
	logic                      is_store;
	logic                      fsm_req;
	logic                      fsm_we;
	logic                      cnt_en;
	logic                      cnt_clr;
	logic                      capture;
	logic                      done;
	logic                      err;
	logic                      expired;
	logic [3:0]                be;
	logic [`WB_WORD_WIDTH-1:0] lane_wdata;
	logic                      misaligned;
	logic [`WB_WORD_WIDTH-1:0] load_data;

	////////////////////////////////////////////////////////////
	// Operation register and decode
	////////////////////////////////////////////////////////////

	assign op_ready_o = ~busy;
	assign start      = op_valid_i & ~busy;

	always_ff @(posedge clk) begin
		if (start) begin
			op_q <= op_i;
		end
	end

	// While idle the incoming op is decoded so the FSM can branch on acceptance
	assign op_cur   = busy ? op_q : op_i;
	assign is_load  = (op_cur.load_type != LD_NONE);
	assign is_store = (op_cur.store_type != ST_NONE);

	lsu_fsm u_fsm (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.start_i      (start),
		.is_mem_i     (is_load | is_store),
		.is_store_i   (is_store),
		.misaligned_i (misaligned),
		.gnt_i        (dbus_rsp_i.gnt),
		.rvalid_i     (dbus_rsp_i.rvalid),
		.expired_i    (expired),
		.busy_o       (busy),
		.req_o        (fsm_req),
		.we_o         (fsm_we),
		.cnt_en_o     (cnt_en),
		.cnt_clr_o    (cnt_clr),
		.capture_o    (capture),
		.done_o       (done),
		.err_o        (err)
	);

	bus_timeout u_timeout (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.clear_i    (cnt_clr),
		.count_en_i (cnt_en),
		.expired_o  (expired)
	);

	lsu_align u_align (
		.addr_i       (op_cur.addr),
		.store_data_i (op_cur.store_data),
		.load_type_i  (op_cur.load_type),
		.store_type_i (op_cur.store_type),
		.rdata_i      (dbus_rsp_i.rdata),
		.be_o         (be),
		.wdata_o      (lane_wdata),
		.misaligned_o (misaligned),
		.load_data_o  (load_data)
	);

	////////////////////////////////////////////////////////////
	// Data bus request
	////////////////////////////////////////////////////////////

	// Fields only change on acceptance, so they stay put while req waits
	always_comb begin
		dbus_req_o.req   = fsm_req;
		dbus_req_o.we    = fsm_we;
		dbus_req_o.be    = be;
		dbus_req_o.addr  = op_cur.addr;
		dbus_req_o.wdata = lane_wdata;
	end

	////////////////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////////////////

	// Extended load data latched with rvalid
	always_ff @(posedge clk) begin
		if (capture) begin
			load_q <= load_data;
		end
	end

	assign wb_valid_o = done;

	// Built only from registers, valid in the DONE cycle
	always_comb begin
		wb_res_o.err = err;
		if (err) begin
			wb_res_o.wdata = '0;
		end else if (is_load) begin
			wb_res_o.wdata = load_q;
		end else begin
			wb_res_o.wdata = op_q.wb_data;
		end
	end

endmodule

/* hw/lsu_align.sv */
// Byte lane logic of the load/store path, purely combinational
// Places store data on its lanes with byte enables, checks alignment
// and extracts and extends load data from the returned word

`timescale 1ns/1ns

`include "wb_consts.svh"

module lsu_align import wb_pkg::*; (
	input  logic [`WB_WORD_WIDTH-1:0] addr_i,
	input  logic [`WB_WORD_WIDTH-1:0] store_data_i,
	input  load_type_e                load_type_i,
	input  store_type_e               store_type_i,
	input  logic [`WB_WORD_WIDTH-1:0] rdata_i,
	output logic [3:0]                be_o,
	output logic [`WB_WORD_WIDTH-1:0] wdata_o,
	output logic                      misaligned_o,
	output logic [`WB_WORD_WIDTH-1:0] load_data_o
);

	localparam int W = `WB_WORD_WIDTH;

	logic [1:0]   offset;
	logic [W-1:0] rdata_shift;

	// Byte offset inside the word
	assign offset = addr_i[1:0];

	////////////////////////////////////////////////////////////
	// Store lanes
	////////////////////////////////////////////////////////////

	// Replicated data lets the byte enables alone pick the lane
	always_comb begin
		case (store_type_i)
			ST_B: begin
				wdata_o = {4{store_data_i[7:0]}};
				be_o    = 4'b0001 << offset;
			end
			ST_H: begin
				wdata_o = {2{store_data_i[15:0]}};
				be_o    = 4'b0011 << offset;
			end
			ST_W: begin
				wdata_o = store_data_i;
				be_o    = 4'b1111;
			end
			default: begin
				wdata_o = store_data_i;
				be_o    = 4'b0000;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Alignment check
	////////////////////////////////////////////////////////////

	always_comb begin
		misaligned_o = 1'b0;
		// Halfword needs an even address
		if (load_type_i == LD_H || load_type_i == LD_HU || store_type_i == ST_H) begin
			misaligned_o = offset[0];
		end
		// Word needs a multiple of 4
		if (load_type_i == LD_W || store_type_i == ST_W) begin
			misaligned_o = |offset;
		end
	end

	////////////////////////////////////////////////////////////
	// Load extraction
	////////////////////////////////////////////////////////////

	// Addressed byte or halfword moved down to bit 0
	assign rdata_shift = rdata_i >> {offset, 3'b000};

	always_comb begin
		case (load_type_i)
			LD_B:    load_data_o = {{(W-8){rdata_shift[7]}}, rdata_shift[7:0]};
			LD_BU:   load_data_o = {{(W-8){1'b0}}, rdata_shift[7:0]};
			LD_H:    load_data_o = {{(W-16){rdata_shift[15]}}, rdata_shift[15:0]};
			LD_HU:   load_data_o = {{(W-16){1'b0}}, rdata_shift[15:0]};
			default: load_data_o = rdata_i;
		endcase
	end

endmodule

/* hw/bus_timeout.sv */
// Wait counter for data bus transactions
// Counts cycles spent waiting for gnt or rvalid and flags when the
// bus timeout is reached, saturating there until cleared

`timescale 1ns/1ns

`include "wb_consts.svh"

module bus_timeout (
	input  logic clk,
	input  logic rst_n_i,
	input  logic clear_i,
	input  logic count_en_i,
	output logic expired_o
);

	localparam int LIMIT = `WB_BUS_TIMEOUT;
	// Wide enough to hold LIMIT itself
	localparam int CNT_W = $clog2(LIMIT + 1);

	logic [CNT_W-1:0] cnt_q;

	assign expired_o = (cnt_q == CNT_W'(LIMIT));

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (clear_i) begin
			// Clear wins over counting
			cnt_q <= '0;
		end else if (count_en_i && !expired_o) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

endmodule

/* hw/lsu_fsm.sv */
// Control FSM of the memory and writeback stage
// Runs at most one data bus transaction per accepted operation and
// ends every operation with a single DONE cycle, the writeback pulse

`timescale 1ns/1ns

module lsu_fsm (
	input  logic clk,
	input  logic rst_n_i,
	input  logic start_i,
	input  logic is_mem_i,
	input  logic is_store_i,
	input  logic misaligned_i,
	input  logic gnt_i,
	input  logic rvalid_i,
	input  logic expired_i,
	output logic busy_o,
	output logic req_o,
	output logic we_o,
	output logic cnt_en_o,
	output logic cnt_clr_o,
	output logic capture_o,
	output logic done_o,
	output logic err_o
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_RSP,
		DONE
	} state_e;

	state_e state_q;
	state_e state_n;
	logic   err_q;
	logic   abort;

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		state_n   = state_q;
		cnt_en_o  = 1'b0;
		cnt_clr_o = 1'b0;
		capture_o = 1'b0;
		abort     = 1'b0;
		case (state_q)
			IDLE: begin
				if (start_i) begin
					// Fresh timeout budget for the new operation
					cnt_clr_o = 1'b1;
					// Plain and misaligned operations never touch the bus
					if (is_mem_i && !misaligned_i) begin
						state_n = REQ;
					end else begin
						state_n = DONE;
					end
				end
			end
			REQ: begin
				if (gnt_i) begin
					// Response wait gets its own budget
					cnt_clr_o = 1'b1;
					state_n   = WAIT_RSP;
				end else if (expired_i) begin
					abort   = 1'b1;
					state_n = DONE;
				end else begin
					cnt_en_o = 1'b1;
				end
			end
			WAIT_RSP: begin
				if (rvalid_i) begin
					// Read data is only valid in this cycle
					capture_o = 1'b1;
					state_n   = DONE;
				end else if (expired_i) begin
					abort   = 1'b1;
					state_n = DONE;
				end else begin
					cnt_en_o = 1'b1;
				end
			end
			default: begin
				state_n = IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// State and error flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			err_q   <= 1'b0;
		end else begin
			state_q <= state_n;
			// Error is decided at acceptance or on a bus abort
			if (state_q == IDLE && start_i) begin
				err_q <= is_mem_i & misaligned_i;
			end else if (abort) begin
				err_q <= 1'b1;
			end
		end
	end

	// Outputs straight from the state register
	assign busy_o = (state_q != IDLE);
	assign req_o  = (state_q == REQ);
	assign we_o   = req_o & is_store_i;
	assign done_o = (state_q == DONE);
	assign err_o  = err_q;

endmodule

/* hw/wb_pkg.sv */
// Types shared by the writeback stage, the data RAM and the testbench
// Modules pull these in with a wildcard import in their header

`include "wb_consts.svh"

package wb_pkg;

	////////////////////////////////////////////////////////////
	// Load and store encodings
	////////////////////////////////////////////////////////////

	// Bit 2 marks the unsigned variants of byte and halfword
	typedef enum logic [2:0] {
		LD_NONE = 3'b000,
		LD_B    = 3'b001,
		LD_H    = 3'b010,
		LD_W    = 3'b100,
		LD_BU   = 3'b101,
		LD_HU   = 3'b110
	} load_type_e;

	typedef enum logic [1:0] {
		ST_NONE = 2'b00,
		ST_B    = 2'b01,
		ST_H    = 2'b10,
		ST_W    = 2'b11
	} store_type_e;

	////////////////////////////////////////////////////////////
	// Stage operation and result
	////////////////////////////////////////////////////////////

	// One operation from the execute stage
	typedef struct packed {
		logic [`WB_WORD_WIDTH-1:0] addr;        // ALU result, address for loads and stores
		logic [`WB_WORD_WIDTH-1:0] wb_data;     // Writeback value of plain operations
		logic [`WB_WORD_WIDTH-1:0] store_data;
		load_type_e                load_type;
		store_type_e               store_type;
	} wb_op_t;

	// Value handed to the register file
	typedef struct packed {
		logic [`WB_WORD_WIDTH-1:0] wdata;
		logic                      err;
	} wb_result_t;

	////////////////////////////////////////////////////////////
	// Data bus
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                      req;
		logic                      we;
		logic [3:0]                be;
		logic [`WB_WORD_WIDTH-1:0] addr;
		logic [`WB_WORD_WIDTH-1:0] wdata;
	} dbus_req_t;

	typedef struct packed {
		logic                      gnt;
		logic                      rvalid;
		logic [`WB_WORD_WIDTH-1:0] rdata;
	} dbus_rsp_t;

endpackage

/* include/wb_consts.svh */
// Shared constants for the memory and writeback stage and its data RAM
// Included by the package, the RTL and the testbench wherever a width,
// the RAM size or the bus timeout is needed

`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

// Data and address width of the core
`define WB_WORD_WIDTH 32

////////////////////////////////////////////////////////////
// Memory system
////////////////////////////////////////////////////////////

// Data RAM size in bytes, addresses at or above are never granted
`define WB_RAM_BYTES 1024

// Cycles spent waiting for gnt or rvalid before the access aborts
`define WB_BUS_TIMEOUT 16

`endif
